/* hdl/sauPkg.sv */
// Widths, opcode/function/combine/count/check/cause enums and the filler word
`default_nettype none

package sauPkg;

	// ======================================================================
	// Widths
	// ======================================================================
	localparam int dataWidth = 64;
	localparam int shiftWidth = 6;	// Shift amount bits taken from b
	localparam int countWidth = 7;	// Holds 0 to 64

	// Value driven for an unrecognised opcode
	localparam logic [dataWidth-1:0] fillerWord = {4{16'hDEAD}};

	// ======================================================================
	// Encodings
	// ======================================================================
	typedef enum logic [3:0] {
		OP_R3 = 4'd0,	// Register-register
		OP_R1 = 4'd1,	// Single operand bit counts
		OP_ADDI = 4'd2,
		OP_ANDI = 4'd3,
		OP_ORI = 4'd4,
		OP_XORI = 4'd5,
		OP_SUBFI = 4'd6,	// imm - a
		OP_CHK = 4'd7,
		OP_NOP = 4'd8
	} opcode_e;

	typedef enum logic [4:0] {
		FN_ADD = 5'd0,
		FN_SUB = 5'd1,
		FN_AND = 5'd2,
		FN_OR = 5'd3,
		FN_XOR = 5'd4,
		FN_MOVE = 5'd5,
		FN_ASL = 5'd6,
		FN_LSR = 5'd7,
		FN_ASR = 5'd8,
		FN_ROL = 5'd9,
		FN_ROR = 5'd10,
		FN_SEQ = 5'd11,
		FN_SNE = 5'd12,
		FN_SLT = 5'd13,
		FN_SLE = 5'd14,
		FN_SLTU = 5'd15,
		FN_SLEU = 5'd16
	} func_e;

	// How the raw result is merged with c
	typedef enum logic [2:0] {
		COMB_AND = 3'd0,
		COMB_OR = 3'd1,
		COMB_XOR = 3'd2,
		COMB_ADD = 3'd3
	} combine_e;

	typedef enum logic [1:0] {
		CNT_LZ = 2'd0,
		CNT_POP = 2'd1,
		CNT_LO = 2'd2,
		CNT_TZ = 2'd3
	} count_e;

	// Bounds check conditions, OUT faults outside the range and IN inside it
	typedef enum logic [3:0] {
		CHK_OUT_GELT = 4'd0,
		CHK_OUT_GELE = 4'd1,
		CHK_OUT_GTLT = 4'd2,
		CHK_OUT_GTLE = 4'd3,
		CHK_IN_GELT = 4'd4,
		CHK_IN_GELE = 4'd5,
		CHK_IN_GTLT = 4'd6,
		CHK_IN_GTLE = 4'd7,
		CHK_CPL_LO = 4'd8,	// a below privilege level
		CHK_CPL_HI = 4'd9,
		CHK_CANARY = 4'd10
	} chkCond_e;

	typedef enum logic [1:0] {
		CAUSE_NONE = 2'd0,
		CAUSE_CHK = 2'd1,
		CAUSE_UNIMP = 2'd2
	} cause_e;

endpackage

`default_nettype wire

/* hdl/sauShifter.sv */
// Left, logical right and arithmetic right shifts plus left and right rotates
`timescale 1ns/1ns
`default_nettype none

module sauShifter
(
	input logic [sauPkg::dataWidth-1:0] a,
	input logic [sauPkg::dataWidth-1:0] b,
	output logic [sauPkg::dataWidth-1:0] shl,
	output logic [sauPkg::dataWidth-1:0] shr,
	output logic [sauPkg::dataWidth-1:0] asr,
	output logic [sauPkg::dataWidth-1:0] rol,
	output logic [sauPkg::dataWidth-1:0] ror
);
	import sauPkg::*;

	logic [shiftWidth-1:0] amt;
	logic [2*dataWidth-1:0] rolWide;
	logic [2*dataWidth-1:0] rorWide;

	assign amt = b[shiftWidth-1:0];	// Only the low bits count

	assign shl = a << amt;
	assign shr = a >> amt;
	assign asr = $signed(a) >>> amt;

	// Rotates shift a doubled copy of a, the wrapped bits land in the kept half
	always_comb
	begin
		rolWide = {a, a} << amt;
		rorWide = {a, a} >> amt;
	end

	assign rol = rolWide[2*dataWidth-1:dataWidth];	// Upper half
	assign ror = rorWide[dataWidth-1:0];	// Lower half

endmodule

`default_nettype wire

/* hdl/sauBitCount.sv */
// Leading zero, leading one, trailing zero and population counts of a
`timescale 1ns/1ns
`default_nettype none

module sauBitCount
(
	input logic [sauPkg::dataWidth-1:0] a,
	output logic [sauPkg::countWidth-1:0] lzCnt,
	output logic [sauPkg::countWidth-1:0] loCnt,
	output logic [sauPkg::countWidth-1:0] tzCnt,
	output logic [sauPkg::countWidth-1:0] popCnt
);
	import sauPkg::*;

	logic [dataWidth-1:0] aRev;

	// Zeros above the first set bit, 64 for a zero word
	function automatic logic [countWidth-1:0] fnLeadZeros(input logic [dataWidth-1:0] v);
		logic [countWidth-1:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = dataWidth - 1; i >= 0; i--)
		begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	// Trailing zeros become leading zeros once the word is mirrored
	always_comb
	begin
		for (int i = 0; i < dataWidth; i++)
			aRev[i] = a[dataWidth-1-i];
	end

	assign lzCnt = fnLeadZeros(a);
	assign loCnt = fnLeadZeros(~a);	// Ones counted as inverted zeros
	assign tzCnt = fnLeadZeros(aRev);

	always_comb
	begin
		popCnt = '0;
		for (int i = 0; i < dataWidth; i++)
			popCnt = popCnt + {{(countWidth-1){1'b0}}, a[i]};
	end

endmodule

`default_nettype wire

/* hdl/sauBoundsCheck.sv */
// Bounds check condition evaluation and cause code for the CHK operation
`timescale 1ns/1ns
`default_nettype none

module sauBoundsCheck
(
	input sauPkg::opcode_e op,
	input sauPkg::chkCond_e chkCond,
	input logic [sauPkg::dataWidth-1:0] a,
	input logic [sauPkg::dataWidth-1:0] b,
	input logic [sauPkg::dataWidth-1:0] c,
	input logic [sauPkg::dataWidth-1:0] canary,
	input logic [7:0] cpl,
	output sauPkg::cause_e chkCause
);
	import sauPkg::*;

	logic geLo;
	logic gtLo;
	logic ltHi;
	logic leHi;
	logic [dataWidth-1:0] cplWide;

	// All comparisons unsigned
	assign geLo = a >= b;
	assign gtLo = a > b;
	assign ltHi = a < c;
	assign leHi = a <= c;
	assign cplWide = {{(dataWidth-8){1'b0}}, cpl};

	always_comb
	begin
		chkCause = CAUSE_NONE;
		if (op == OP_CHK)
		begin
			case (chkCond)
			CHK_OUT_GELT:	if (!(geLo && ltHi)) chkCause = CAUSE_CHK;
			CHK_OUT_GELE:	if (!(geLo && leHi)) chkCause = CAUSE_CHK;
			CHK_OUT_GTLT:	if (!(gtLo && ltHi)) chkCause = CAUSE_CHK;
			CHK_OUT_GTLE:	if (!(gtLo && leHi)) chkCause = CAUSE_CHK;
			CHK_IN_GELT:	if (geLo && ltHi) chkCause = CAUSE_CHK;
			CHK_IN_GELE:	if (geLo && leHi) chkCause = CAUSE_CHK;
			CHK_IN_GTLT:	if (gtLo && ltHi) chkCause = CAUSE_CHK;
			CHK_IN_GTLE:	if (gtLo && leHi) chkCause = CAUSE_CHK;
			CHK_CPL_LO:	if (a < cplWide) chkCause = CAUSE_CHK;
			CHK_CPL_HI:	if (a > cplWide) chkCause = CAUSE_CHK;
			CHK_CANARY:	if (a != canary) chkCause = CAUSE_CHK;	// Stack smash
			default:	chkCause = CAUSE_UNIMP;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/sauResultMux.sv */
// Opcode and function decode, combine stage, and the result and cause registers
`timescale 1ns/1ns
`default_nettype none

module sauResultMux
(
	input logic clk,
	input logic rstN,
	input sauPkg::opcode_e op,
	input sauPkg::func_e func,
	input sauPkg::combine_e combine,
	input sauPkg::count_e countSel,
	input logic [sauPkg::dataWidth-1:0] a,
	input logic [sauPkg::dataWidth-1:0] b,
	input logic [sauPkg::dataWidth-1:0] c,
	input logic [sauPkg::dataWidth-1:0] imm,
	input logic [sauPkg::dataWidth-1:0] t,
	input logic [sauPkg::dataWidth-1:0] shl,
	input logic [sauPkg::dataWidth-1:0] shr,
	input logic [sauPkg::dataWidth-1:0] asr,
	input logic [sauPkg::dataWidth-1:0] rol,
	input logic [sauPkg::dataWidth-1:0] ror,
	input logic [sauPkg::countWidth-1:0] lzCnt,
	input logic [sauPkg::countWidth-1:0] loCnt,
	input logic [sauPkg::countWidth-1:0] tzCnt,
	input logic [sauPkg::countWidth-1:0] popCnt,
	input sauPkg::cause_e chkCause,
	output logic [sauPkg::dataWidth-1:0] result,
	output sauPkg::cause_e excO
);
	import sauPkg::*;

	logic [dataWidth-1:0] raw;	// Function result before combine
	logic [dataWidth-1:0] combined;
	logic [countWidth-1:0] cnt;
	logic cmpBit;
	logic combValid;
	logic [dataWidth-1:0] nextResult;

	// ======================================================================
	// Register-register datapath
	// ======================================================================
	always_comb
	begin
		case (func)
		FN_ADD:	raw = a + b;
		FN_SUB:	raw = a - b;
		FN_AND:	raw = a & b;
		FN_OR:	raw = a | b;
		FN_XOR:	raw = a ^ b;
		FN_ASL:	raw = shl;
		FN_LSR:	raw = shr;
		FN_ROL:	raw = rol;
		FN_ROR:	raw = ror;
		default:	raw = '0;
		endcase
	end

	always_comb
	begin
		case (combine)
		COMB_AND:	combined = raw & c;
		COMB_OR:	combined = raw | c;
		COMB_XOR:	combined = raw ^ c;
		// Subtract chains a second subtract
		COMB_ADD:	combined = (func == FN_SUB) ? raw - c : raw + c;
		default:	combined = '0;
		endcase
	end

	assign combValid = combine inside {COMB_AND, COMB_OR, COMB_XOR, COMB_ADD};

	// Set compares
	always_comb
	begin
		case (func)
		FN_SEQ:	cmpBit = a == b;
		FN_SNE:	cmpBit = a != b;
		FN_SLT:	cmpBit = $signed(a) < $signed(b);
		FN_SLE:	cmpBit = $signed(a) <= $signed(b);
		FN_SLTU:	cmpBit = a < b;
		FN_SLEU:	cmpBit = a <= b;
		default:	cmpBit = 1'b0;
		endcase
	end

	always_comb
	begin
		case (countSel)
		CNT_LZ:	cnt = lzCnt;
		CNT_POP:	cnt = popCnt;
		CNT_LO:	cnt = loCnt;
		default:	cnt = tzCnt;	// CNT_TZ
		endcase
	end

	// ======================================================================
	// Result select
	// ======================================================================
	always_comb
	begin
		case (op)
		OP_R3:
			case (func)
			FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
			FN_ASL, FN_LSR, FN_ROL, FN_ROR:
				nextResult = combined;
			FN_ASR:	nextResult = combValid ? asr : '0;	// Combine c not applied
			FN_MOVE:	nextResult = b;
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				nextResult = {{(dataWidth-1){1'b0}}, cmpBit};
			default:	nextResult = '0;
			endcase
		OP_R1:	nextResult = {{(dataWidth-countWidth){1'b0}}, cnt};
		OP_ADDI:	nextResult = a + imm;
		OP_ANDI:	nextResult = a & imm;
		OP_ORI:	nextResult = a | imm;
		OP_XORI:	nextResult = a ^ imm;
		OP_SUBFI:	nextResult = imm - a;
		OP_CHK:	nextResult = '0;	// Only the cause matters
		OP_NOP:	nextResult = t;	// Target passes through
		default:	nextResult = fillerWord;
		endcase
	end

	// One cycle of latency, a new operation every clock
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			result <= '0;
			excO <= CAUSE_NONE;
		end
		else
		begin
			result <= nextResult;
			excO <= chkCause;
		end
	end

endmodule

`default_nettype wire

/* hdl/sau.sv */
// Top level of the scalar arithmetic unit, operand units feeding the result selector
`timescale 1ns/1ns
`default_nettype none

module sau
(
	input logic clk,
	input logic rstN,
	input sauPkg::opcode_e op,
	input sauPkg::func_e func,
	input sauPkg::combine_e combine,
	input sauPkg::count_e countSel,
	input sauPkg::chkCond_e chkCond,
	input logic [sauPkg::dataWidth-1:0] a,
	input logic [sauPkg::dataWidth-1:0] b,
	input logic [sauPkg::dataWidth-1:0] c,
	input logic [sauPkg::dataWidth-1:0] imm,
	input logic [sauPkg::dataWidth-1:0] t,	// Target register value
	input logic [7:0] cpl,	// Current privilege level
	input logic [sauPkg::dataWidth-1:0] canary,
	output logic [sauPkg::dataWidth-1:0] result,
	output sauPkg::cause_e excO
);
	import sauPkg::*;

	logic [dataWidth-1:0] shl;
	logic [dataWidth-1:0] shr;
	logic [dataWidth-1:0] asr;
	logic [dataWidth-1:0] rol;
	logic [dataWidth-1:0] ror;
	logic [countWidth-1:0] lzCnt;
	logic [countWidth-1:0] loCnt;
	logic [countWidth-1:0] tzCnt;
	logic [countWidth-1:0] popCnt;
	cause_e chkCause;

	// Operand units, all combinational
	sauShifter uShifter
	(
		.a(a),
		.b(b),
		.shl(shl),
		.shr(shr),
		.asr(asr),
		.rol(rol),
		.ror(ror)
	);

	sauBitCount uBitCount
	(
		.a(a),
		.lzCnt(lzCnt),
		.loCnt(loCnt),
		.tzCnt(tzCnt),
		.popCnt(popCnt)
	);

	sauBoundsCheck uBoundsCheck
	(
		.op(op),
		.chkCond(chkCond),
		.a(a),
		.b(b),
		.c(c),
		.canary(canary),
		.cpl(cpl),
		.chkCause(chkCause)
	);

	// Selector and output registers
	sauResultMux uResultMux
	(
		.clk(clk),
		.rstN(rstN),
		.op(op),
		.func(func),
		.combine(combine),
		.countSel(countSel),
		.a(a),
		.b(b),
		.c(c),
		.imm(imm),
		.t(t),
		.shl(shl),
		.shr(shr),
		.asr(asr),
		.rol(rol),
		.ror(ror),
		.lzCnt(lzCnt),
		.loCnt(loCnt),
		.tzCnt(tzCnt),
		.popCnt(popCnt),
		.chkCause(chkCause),
		.result(result),
		.excO(excO)
	);

endmodule

`default_nettype wire

/* tests/sau_sva.sv */
// Bound checker with a reference model of the arithmetic unit and the output assertions
`timescale 1ns/1ns
`default_nettype none

module sau_sva
(
	input logic clk,
	input logic rstN,
	input sauPkg::opcode_e op,
	input sauPkg::func_e func,
	input sauPkg::combine_e combine,
	input sauPkg::count_e countSel,
	input sauPkg::chkCond_e chkCond,
	input logic [sauPkg::dataWidth-1:0] a, b, c, imm, t, canary, result,
	input logic [7:0] cpl,
	input sauPkg::cause_e excO
);
	import sauPkg::*;

	logic [dataWidth-1:0] expResult;
	logic [dataWidth-1:0] prevResult;	// Expected value for the current output
	cause_e expCause;
	cause_e prevCause;
	logic prevRstN;
	int failCount = 0;	// Read by the testbench

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic logic [6:0] countOf(input logic [1:0] sel, input logic [63:0] v);
		logic [6:0] n;
		n = '0;
		case (sel)
		CNT_LZ:
			for (int i = 63; i >= 0 && !v[i]; i--)
				n = n + 7'd1;
		CNT_LO:
			for (int i = 63; i >= 0 && v[i]; i--)
				n = n + 7'd1;
		CNT_TZ:
			for (int i = 0; i < 64 && !v[i]; i++)
				n = n + 7'd1;
		default:
			n = 7'($countones(v));
		endcase
		return n;
	endfunction

	function automatic logic [63:0] expectResult(input logic [3:0] opc, input logic [4:0] fn,
			input logic [2:0] mode, input logic [1:0] sel,
			input logic [63:0] x, y, z, im, tv);
		logic [63:0] raw;
		logic [63:0] sra;
		logic [6:0] n;
		n = {1'b0, y[5:0]};
		sra = $signed(x) >>> n;
		case (fn)
		FN_ADD: raw = x + y;
		FN_SUB: raw = x - y;
		FN_AND: raw = x & y;
		FN_OR: raw = x | y;
		FN_XOR: raw = x ^ y;
		FN_ASL: raw = x << n;
		FN_LSR: raw = x >> n;
		FN_ROL: raw = (x << n) | (x >> (7'd64 - n));	// Shift by 64 gives zero
		FN_ROR: raw = (x >> n) | (x << (7'd64 - n));
		default: raw = '0;
		endcase
		case (opc)
		OP_R1: return {57'd0, countOf(sel, x)};
		OP_ADDI: return x + im;
		OP_ANDI: return x & im;
		OP_ORI: return x | im;
		OP_XORI: return x ^ im;
		OP_SUBFI: return im - x;
		OP_CHK: return '0;
		OP_NOP: return tv;
		OP_R3: ;
		default: return fillerWord;
		endcase
		case (fn)
		FN_MOVE: return y;
		FN_SEQ: return {63'd0, x == y};
		FN_SNE: return {63'd0, x != y};
		FN_SLT: return {63'd0, $signed(x) < $signed(y)};
		FN_SLE: return {63'd0, $signed(x) <= $signed(y)};
		FN_SLTU: return {63'd0, x < y};
		FN_SLEU: return {63'd0, x <= y};
		FN_ASR: return (mode > 3'd3) ? '0 : sra;	// No merge with c
		default: ;
		endcase
		case (mode)
		COMB_AND: return raw & z;
		COMB_OR: return raw | z;
		COMB_XOR: return raw ^ z;
		COMB_ADD: return (fn == FN_SUB) ? raw - z : raw + z;
		default: return '0;
		endcase
	endfunction

	function automatic cause_e expectCause(input logic [3:0] opc, cond,
			input logic [63:0] x, lo, hi, can, input logic [7:0] level);
		logic aboveLo;
		logic belowHi;
		aboveLo = cond[1] ? (x > lo) : (x >= lo);	// Bit 1 excludes the low edge
		belowHi = cond[0] ? (x <= hi) : (x < hi);	// Bit 0 includes the high edge
		if (opc != OP_CHK)
			return CAUSE_NONE;
		if (cond <= 4'd3)
			return (aboveLo && belowHi) ? CAUSE_NONE : CAUSE_CHK;
		if (cond <= 4'd7)
			return (aboveLo && belowHi) ? CAUSE_CHK : CAUSE_NONE;
		if (cond == 4'd8)
			return (x < {56'd0, level}) ? CAUSE_CHK : CAUSE_NONE;
		if (cond == 4'd9)
			return (x > {56'd0, level}) ? CAUSE_CHK : CAUSE_NONE;
		if (cond == 4'd10)
			return (x != can) ? CAUSE_CHK : CAUSE_NONE;
		return CAUSE_UNIMP;
	endfunction

	assign expResult = expectResult(op, func, combine, countSel, a, b, c, imm, t);
	assign expCause = expectCause(op, chkCond, a, b, c, canary, cpl);

	always_ff @(posedge clk)
	begin
		prevResult <= expResult;
		prevCause <= expCause;
		prevRstN <= rstN;
	end

	// ======================================================================
	// Output checks, one cycle after the inputs
	// ======================================================================
	resultCheck: assert property (@(posedge clk) prevRstN |-> result == prevResult)
		else
		begin
			failCount++;
			$error("CHECK FAILED at %0t: result is %h, expected %h",
				$time, $sampled(result), $sampled(prevResult));
		end

	causeCheck: assert property (@(posedge clk) prevRstN |-> excO == prevCause)
		else
		begin
			failCount++;
			$error("CHECK FAILED at %0t: excO is %0d, expected %0d",
				$time, $sampled(excO), $sampled(prevCause));
		end

	resetResult: assert property (@(posedge clk) !prevRstN |-> result == '0)
		else
		begin
			failCount++;
			$error("CHECK FAILED at %0t: result is %h, expected 0", $time, $sampled(result));
		end

	resetCause: assert property (@(posedge clk) !prevRstN |-> excO == CAUSE_NONE)
		else
		begin
			failCount++;
			$error("CHECK FAILED at %0t: excO is %0d, expected 0", $time, $sampled(excO));
		end

endmodule

`default_nettype wire

/* tests/sauTb.sv */
// Testbench for the arithmetic unit with xorshift stimulus, report lines and a watchdog
`timescale 1ns/1ns
`default_nettype none

module sauTb;
	import sauPkg::*;

	localparam int resetCycles = 8;
	localparam int numOps = 196;	// Sum of the operations issued by all tests
	localparam int timeLimit = (numOps + resetCycles + 20) * 40;

	logic clk;
	logic rstN;
	opcode_e op;
	func_e func;
	combine_e combine;
	count_e countSel;
	chkCond_e chkCond;
	logic [dataWidth-1:0] a, b, c, imm, t, canary, result;
	logic [7:0] cpl;
	cause_e excO;
	logic [63:0] rngState;
	int opCount;
	int testCount;
	int failsBefore;
	func_e logicFns[5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR};
	func_e shiftFns[5] = '{FN_ASL, FN_LSR, FN_ASR, FN_ROL, FN_ROR};
	func_e cmpFns[6] = '{FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU};
	opcode_e immOps[5] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SUBFI};

	sau dut_i (.*);

	bind sau sau_sva svaI
	(
		.clk(clk), .rstN(rstN), .op(op), .func(func), .combine(combine),
		.countSel(countSel), .chkCond(chkCond), .a(a), .b(b), .c(c), .imm(imm),
		.t(t), .canary(canary), .result(result), .cpl(cpl), .excO(excO)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		#(timeLimit);
		$display("Watchdog: the run did not finish within %0d ns", timeLimit);
		$display("TESTS FAILED");
		$finish;
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic logic [63:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 7);
		rngState = rngState ^ (rngState << 17);
		return rngState;
	endfunction

	// Inputs change right after the falling edge
	task automatic nextOp();
		@(negedge clk);
		opCount++;
	endtask

	task automatic finishTest(input string name);
		int fails;
		repeat (2) @(negedge clk);	// Lets the last check fire
		fails = dut_i.svaI.failCount - failsBefore;
		failsBefore = dut_i.svaI.failCount;
		testCount++;
		$display("test %s finished, %0d assertion failures", name, fails);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	initial
	begin
		rngState = 64'd93;
		opCount = 0;
		testCount = 0;
		failsBefore = 0;
		rstN = 1'b0;
		op = OP_NOP;
		func = FN_ADD;
		combine = COMB_AND;
		countSel = CNT_LZ;
		chkCond = CHK_OUT_GELT;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		t = 64'h0123_4567_89AB_CDEF;	// Would show up if reset failed
		cpl = 8'd0;
		canary = '0;
		repeat (resetCycles / 2) @(negedge clk);
		// Undefined condition raises a cause that reset has to hold off
		op = OP_CHK;
		chkCond = chkCond_e'(4'd15);
		repeat (resetCycles - resetCycles / 2) @(negedge clk);
		rstN = 1'b1;
		finishTest("reset");

		for (int f = 0; f < 5; f++)
			for (int m = 0; m < 5; m++)
				repeat (2)
				begin
					nextOp();
					op = OP_R3;
					func = logicFns[f];
					combine = combine_e'(m);
					a = xorshift();
					b = xorshift();
					c = xorshift();
				end
		finishTest("combine");

		for (int f = 0; f < 5; f++)
			for (int k = 0; k < 8; k++)
			begin
				nextOp();
				func = shiftFns[f];
				combine = combine_e'(k % 5);
				a = xorshift();
				b = xorshift();
				c = xorshift();
				if (k == 0)
					b[5:0] = 6'd0;
				else if (k == 1)
					b[5:0] = 6'd63;
			end
		finishTest("shift");

		// Pairs 2 and 3 differ only in the sign bit
		for (int f = 0; f < 6; f++)
			for (int k = 0; k < 4; k++)
			begin
				nextOp();
				func = cmpFns[f];
				a = xorshift();
				if (k >= 2)
					a[63] = (k == 2);
				b = (k == 1) ? a : xorshift();
				if (k >= 2)
					b = a ^ {1'b1, 63'd0};
			end
		for (int k = 0; k < 10; k++)
		begin
			nextOp();
			op = immOps[k % 5];
			a = xorshift();
			imm = xorshift();
		end
		for (int k = 0; k < 3; k++)
		begin
			nextOp();
			op = (k == 0) ? OP_R3 : (k == 1) ? OP_NOP : opcode_e'(4'hC);
			func = FN_MOVE;
			b = xorshift();
			t = xorshift();
		end
		finishTest("misc");

		for (int k = 0; k < 16; k++)
		begin
			nextOp();
			op = OP_R1;
			countSel = count_e'(k % 4);
			a = (k < 4) ? '0 : (k < 8) ? '1 : xorshift();
		end
		finishTest("count");

		for (int k = 0; k < 8; k++)
			for (int p = 0; p < 5; p++)
			begin
				nextOp();
				op = OP_CHK;
				chkCond = chkCond_e'(k);
				b = (xorshift() >> 33) + 64'd1;
				c = b + 64'd8 + (xorshift() >> 60);
				case (p)
				0: a = b - 64'd1;
				1: a = b;
				2: a = b + 64'd1;	// Strictly inside
				3: a = c;
				default: a = c + 64'd1;
				endcase
			end
		for (int k = 0; k < 13; k++)
		begin
			nextOp();
			chkCond = (k < 3) ? CHK_CPL_LO : (k < 6) ? CHK_CPL_HI :
				(k < 8) ? CHK_CANARY : chkCond_e'(k + 3);
			canary = xorshift();
			cpl = canary[7:0] | 8'd1;
			a = {56'd0, cpl} + 64'(k % 3) - 64'd1;	// One below, at, one above
			if (k == 6)
				a = canary;
		end
		finishTest("bounds");

		$display("%0d tests, %0d operations, %0d assertion failures",
			testCount, opCount, dut_i.svaI.failCount);
		if (dut_i.svaI.failCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/sauPkg.sv
hdl/sauShifter.sv
hdl/sauBitCount.sv
hdl/sauBoundsCheck.sv
hdl/sauResultMux.sv
hdl/sau.sv
tests/sau_sva.sv
tests/sauTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sauTb -f flist.f -o sauSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sauSim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
exit 1
